// ==== hdl/pong_pkg.sv ====
`default_nettype none

package pong_pkg;

    // Pixel coordinates
    typedef logic [9:0] x_coord_t;
    typedef logic [8:0] y_coord_t;

    // Per-tick velocity of one axis, +1 or -1 only
    typedef logic signed [1:0] step_t;

    // Saturating count of balls lost at the left wall
    typedef logic [7:0] miss_count_t;

    typedef struct packed {
        x_coord_t ball_x;   // Ball centre
        y_coord_t ball_y;
        step_t    ball_dx;  // Ball velocity
        step_t    ball_dy;
        y_coord_t paddle_y; // Top line of the paddle
    } game_state_t;

    typedef struct packed {
        logic up;
        logic down;
    } buttons_t;

    typedef enum logic {
        db_idle,      // Output stable
        db_counting   // Input differs, timing it
    } debounce_state_t;

    // Fixed geometry
    localparam int unsigned BALL_HALF      = 4;
    localparam x_coord_t    PADDLE_X_LEFT  = 10'd16;
    localparam x_coord_t    PADDLE_X_RIGHT = 10'd19;

endpackage

`default_nettype wire

// ==== hdl/button_debounce.sv ====
`timescale 1ns/1ps
`default_nettype none

module button_debounce
    import pong_pkg::*;
#(
    parameter int DEBOUNCE_CYCLES = 250000
) (
    input  logic clk,
    input  logic rst_n,
    input  logic button_in,
    output logic button_out
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    logic            sync_0;
    logic            sync_1;
    debounce_state_t db_state;
    logic [CNT_W-1:0] count;

    // Two-flop synchronizer for the raw pin
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_0 <= 1'b0;
            sync_1 <= 1'b0;
        end else begin
            sync_0 <= button_in;
            sync_1 <= sync_0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            db_state   <= db_idle;
            count      <= '0;
            button_out <= 1'b0;
        end else begin
            case (db_state)
                db_idle: begin
                    if (sync_1 != button_out) begin
                        db_state <= db_counting;
                        count    <= CNT_W'(1);   // First cycle of difference
                    end
                end
                db_counting: begin
                    if (sync_1 == button_out) begin
                        // Glitch, fell back before the time was up
                        db_state <= db_idle;
                        count    <= '0;
                    end else if (count == CNT_W'(DEBOUNCE_CYCLES)) begin
                        db_state   <= db_idle;
                        count      <= '0;
                        button_out <= sync_1;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                default: db_state <= db_idle;
            endcase
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
        count <= CNT_W'(DEBOUNCE_CYCLES));

endmodule

`default_nettype wire

// ==== hdl/pong_physics.sv ====
`timescale 1ns/1ps
`default_nettype none

module pong_physics
    import pong_pkg::*;
#(
    parameter int SCREEN_WIDTH  = 640,
    parameter int SCREEN_HEIGHT = 480,
    parameter int PADDLE_HEIGHT = 32
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        enable,
    input  buttons_t    buttons,
    output game_state_t state,
    output miss_count_t miss_count
);

    localparam step_t STEP_POS = 2'sb01;
    localparam step_t STEP_NEG = 2'sb11;

    localparam x_coord_t X_MAX      = x_coord_t'(SCREEN_WIDTH - 1);
    localparam y_coord_t Y_MAX      = y_coord_t'(SCREEN_HEIGHT - 1);
    localparam y_coord_t PADDLE_MAX = y_coord_t'(SCREEN_HEIGHT - PADDLE_HEIGHT);
    localparam y_coord_t PADDLE_SPAN = y_coord_t'(PADDLE_HEIGHT - 1);
    localparam x_coord_t BOUNCE_X   = PADDLE_X_RIGHT + 1'b1;  // Column right of the paddle

    localparam game_state_t RESET_STATE = '{
        ball_x:   x_coord_t'(SCREEN_WIDTH / 2),
        ball_y:   y_coord_t'(SCREEN_HEIGHT / 2),
        ball_dx:  STEP_POS,
        ball_dy:  STEP_POS,
        paddle_y: y_coord_t'((SCREEN_HEIGHT - PADDLE_HEIGHT) / 2)
    };

    game_state_t state_d;
    miss_count_t miss_d;
    logic        paddle_hit;

    // Ball moving left, touching the paddle face within its span
    assign paddle_hit = (state.ball_dx == STEP_NEG) &&
                        (state.ball_x == BOUNCE_X) &&
                        (state.ball_y >= state.paddle_y) &&
                        (state.ball_y <= state.paddle_y + PADDLE_SPAN);

    always_comb begin
        state_d = state;
        miss_d  = miss_count;

        // Horizontal, tested on the old position
        if (state.ball_x == '0) begin
            state_d.ball_dx = STEP_POS;
            if (miss_count != '1) begin
                miss_d = miss_count + 1'b1;   // Saturates at all ones
            end
        end else if (state.ball_x == X_MAX) begin
            state_d.ball_dx = STEP_NEG;
        end else if (paddle_hit) begin
            state_d.ball_dx = STEP_POS;
        end

        // Vertical is independent of the horizontal chain
        if (state.ball_y == '0) begin
            state_d.ball_dy = STEP_POS;
        end else if (state.ball_y == Y_MAX) begin
            state_d.ball_dy = STEP_NEG;
        end

        // Move with the updated velocity so the ball never leaves the screen
        state_d.ball_x = (state_d.ball_dx == STEP_POS) ? state.ball_x + 1'b1
                                                       : state.ball_x - 1'b1;
        state_d.ball_y = (state_d.ball_dy == STEP_POS) ? state.ball_y + 1'b1
                                                       : state.ball_y - 1'b1;

        // Paddle, one line per tick, held at the screen edges
        if (buttons.down && !buttons.up && state.paddle_y < PADDLE_MAX) begin
            state_d.paddle_y = state.paddle_y + 1'b1;
        end else if (buttons.up && !buttons.down && state.paddle_y != '0) begin
            state_d.paddle_y = state.paddle_y - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= RESET_STATE;
            miss_count <= '0;
        end else if (enable) begin
            state      <= state_d;
            miss_count <= miss_d;
        end
    end

    a_ball_on_screen: assert property (@(posedge clk) disable iff (!rst_n)
        (state.ball_x <= X_MAX) && (state.ball_y <= Y_MAX));

    a_paddle_clamped: assert property (@(posedge clk) disable iff (!rst_n)
        state.paddle_y <= PADDLE_MAX);

endmodule

`default_nettype wire

// ==== hdl/pong_renderer.sv ====
`timescale 1ns/1ps
`default_nettype none

module pong_renderer
    import pong_pkg::*;
#(
    parameter int PADDLE_HEIGHT = 32
) (
    input  logic        clk,
    input  logic        rst_n,
    input  x_coord_t    x,
    input  y_coord_t    y,
    input  game_state_t state,
    output logic        pixel
);

    localparam x_coord_t HALF_X      = x_coord_t'(BALL_HALF);
    localparam y_coord_t HALF_Y      = y_coord_t'(BALL_HALF);
    localparam y_coord_t PADDLE_SPAN = y_coord_t'(PADDLE_HEIGHT - 1);

    x_coord_t ball_left;
    x_coord_t ball_right;
    y_coord_t ball_top;
    y_coord_t ball_bottom;
    logic     in_ball;
    logic     in_paddle;

    // Lower bounds clip at 0 near the top and left walls
    assign ball_left   = (state.ball_x >= HALF_X) ? state.ball_x - HALF_X : '0;
    assign ball_top    = (state.ball_y >= HALF_Y) ? state.ball_y - HALF_Y : '0;
    assign ball_right  = state.ball_x + HALF_X;
    assign ball_bottom = state.ball_y + HALF_Y;

    assign in_ball = (x >= ball_left) && (x <= ball_right) &&
                     (y >= ball_top)  && (y <= ball_bottom);

    assign in_paddle = (x >= PADDLE_X_LEFT) && (x <= PADDLE_X_RIGHT) &&
                       (y >= state.paddle_y) &&
                       (y <= state.paddle_y + PADDLE_SPAN);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pixel <= 1'b0;
        end else begin
            pixel <= in_ball | in_paddle;   // One cycle after the query
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pong_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pong_top
    import pong_pkg::*;
#(
    parameter int SCREEN_WIDTH    = 640,
    parameter int SCREEN_HEIGHT   = 480,
    parameter int PADDLE_HEIGHT   = 32,
    parameter int DEBOUNCE_CYCLES = 250000
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        enable,        // Frame strobe
    input  logic        btn_up_raw,
    input  logic        btn_down_raw,
    input  x_coord_t    x,
    input  y_coord_t    y,
    output logic        pixel,
    output miss_count_t miss_count
);

    buttons_t    buttons;
    game_state_t state;

    button_debounce #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) debounce_up (
        .clk       (clk),
        .rst_n     (rst_n),
        .button_in (btn_up_raw),
        .button_out(buttons.up)
    );

    button_debounce #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) debounce_down (
        .clk       (clk),
        .rst_n     (rst_n),
        .button_in (btn_down_raw),
        .button_out(buttons.down)
    );

    pong_physics #(
        .SCREEN_WIDTH (SCREEN_WIDTH),
        .SCREEN_HEIGHT(SCREEN_HEIGHT),
        .PADDLE_HEIGHT(PADDLE_HEIGHT)
    ) physics (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .buttons   (buttons),
        .state     (state),
        .miss_count(miss_count)
    );

    pong_renderer #(
        .PADDLE_HEIGHT(PADDLE_HEIGHT)
    ) renderer (
        .clk  (clk),
        .rst_n(rst_n),
        .x    (x),
        .y    (y),
        .state(state),
        .pixel(pixel)
    );

endmodule

`default_nettype wire

// ==== tests/clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;   // Released on an edge like other inputs
    end

endmodule

`default_nettype wire

// ==== tests/pong_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pong_tb
    import pong_pkg::*;
();

    localparam int W  = 64;
    localparam int H  = 48;
    localparam int PH = 8;
    localparam int NUM_STEPS = 10;

    typedef struct packed {
        logic up;
        logic down;
        logic pulse;        // Short glitch on the down button instead of a hold
        int   strobes;
        int   exp_paddle;
        int   exp_miss;
    } step_entry_t;

    // Ball path worked out by hand for the 64 x 48 screen
    step_entry_t steps [0:NUM_STEPS-1] = '{
        '{1'b0, 1'b0, 1'b0, 100, 20, 1},  // Walls, then a miss at x = 0
        '{1'b1, 1'b1, 1'b0, 3,   20, 1},  // Both held, paddle stays
        '{1'b0, 1'b1, 1'b0, 30,  40, 1},  // Down into the clamp
        '{1'b1, 1'b0, 1'b0, 45,  0,  1},  // Up into the clamp
        '{1'b0, 1'b0, 1'b1, 3,   0,  1},  // Glitch rejected
        '{1'b0, 1'b1, 1'b0, 30,  30, 1},  // Ball passes under the paddle
        '{1'b0, 1'b0, 1'b0, 13,  30, 2},  // Second miss
        '{1'b1, 1'b0, 1'b0, 8,   22, 2},  // Park paddle in the ball path
        '{1'b0, 1'b0, 1'b0, 98,  22, 2},  // Paddle bounce at x = 20
        '{1'b0, 1'b0, 1'b0, 30,  22, 2}
    };

    logic        clk;
    logic        rst_n;
    logic        enable;
    logic        btn_up_raw;
    logic        btn_down_raw;
    x_coord_t    qx;
    y_coord_t    qy;
    logic        pixel;
    miss_count_t miss_count;

    int seed = 85710;
    int errors;
    int step_errors;
    int tests_passed;
    int tests_failed;

    // Reference model state
    int m_bx;
    int m_by;
    int m_dx;
    int m_dy;
    int m_py;
    int m_miss;

    clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(4)) clocks (.clk(clk), .rst_n(rst_n));

    pong_top #(
        .SCREEN_WIDTH   (W),
        .SCREEN_HEIGHT  (H),
        .PADDLE_HEIGHT  (PH),
        .DEBOUNCE_CYCLES(4)
    ) uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .enable      (enable),
        .btn_up_raw  (btn_up_raw),
        .btn_down_raw(btn_down_raw),
        .x           (qx),
        .y           (qy),
        .pixel       (pixel),
        .miss_count  (miss_count)
    );

    task automatic model_tick(input logic up, input logic down);
        int  ndx;
        int  ndy;
        logic hit;
        hit = (m_dx == -1) && (m_bx == 20) && (m_by >= m_py) && (m_by <= m_py + PH - 1);
        ndx = m_dx;
        ndy = m_dy;
        if (m_bx == 0) begin
            ndx = 1;
            if (m_miss < 255) m_miss = m_miss + 1;
        end else if (m_bx == W - 1) begin
            ndx = -1;
        end else if (hit) begin
            ndx = 1;
        end
        if (m_by == 0) ndy = 1;
        else if (m_by == H - 1) ndy = -1;
        m_dx = ndx;
        m_dy = ndy;
        m_bx = m_bx + ndx;
        m_by = m_by + ndy;
        if (down && !up && m_py < H - PH) m_py = m_py + 1;
        else if (up && !down && m_py > 0) m_py = m_py - 1;
    endtask

    function automatic logic model_pixel(input int px, input int py);
        int left;
        int top;
        logic in_ball;
        logic in_paddle;
        left = (m_bx >= BALL_HALF) ? m_bx - BALL_HALF : 0;
        top  = (m_by >= BALL_HALF) ? m_by - BALL_HALF : 0;
        in_ball = (px >= left) && (px <= m_bx + BALL_HALF) &&
                  (py >= top) && (py <= m_by + BALL_HALF);
        in_paddle = (px >= 16) && (px <= 19) && (py >= m_py) && (py <= m_py + PH - 1);
        return in_ball | in_paddle;
    endfunction

    task automatic check_pixel(input logic exp, input logic act, input int px, input int py);
        if (exp !== act) begin
            $display("Fail pixel at (%0d,%0d): expected %h, got %h", px, py, exp, act);
            errors++;
            step_errors++;
        end
    endtask

    task automatic check_miss(input miss_count_t exp, input miss_count_t act);
        if (exp !== act) begin
            $display("Fail miss_count: expected %h, got %h", exp, act);
            errors++;
            step_errors++;
        end
    endtask

    // Query one point, pixel is valid one edge later
    task automatic sample_pixel(input int px, input int py, output logic val);
        @(posedge clk);
        qx <= x_coord_t'(px);
        qy <= y_coord_t'(py);
        @(posedge clk);
        @(negedge clk);
        val = pixel;
    endtask

    task automatic query(input int px, input int py);
        logic val;
        if (px >= 0 && py >= 0) begin
            sample_pixel(px, py, val);
            check_pixel(model_pixel(px, py), val, px, py);
        end
    endtask

    task automatic frame_strobe(input logic up, input logic down);
        @(posedge clk);
        enable <= 1'b1;
        @(posedge clk);
        enable <= 1'b0;
        model_tick(up, down);
        repeat (9) @(posedge clk);   // Idle gap between frames
    endtask

    task automatic apply_buttons(input step_entry_t s);
        @(posedge clk);
        if (s.pulse) begin
            btn_up_raw   <= 1'b0;
            btn_down_raw <= 1'b0;
            repeat (12) @(posedge clk);  // Both debounced outputs settle low
            btn_down_raw <= 1'b1;
            repeat (2) @(posedge clk);
            btn_down_raw <= 1'b0;
            // First strobe follows at once, inside the glitch window
        end else begin
            btn_up_raw   <= s.up;
            btn_down_raw <= s.down;
            repeat (12) @(posedge clk);  // Longer than sync plus debounce
        end
    endtask

    task automatic run_step(input step_entry_t s);
        int rx;
        int ry;
        apply_buttons(s);
        for (int i = 0; i < s.strobes; i++) begin
            frame_strobe(s.up & ~s.pulse, s.down & ~s.pulse);
        end
        query(m_bx, m_by);
        query(m_bx + 5, m_by);
        query(m_bx - 5, m_by);
        query(m_bx, m_by + 5);
        query(m_bx, m_by - 5);
        query(17, m_py);
        query(17, m_py + PH);
        query(17, m_py - 1);
        for (int i = 0; i < 4; i++) begin
            rx = {$random(seed)} % W;
            ry = {$random(seed)} % H;
            query(rx, ry);
        end
        check_miss(miss_count_t'(m_miss), miss_count);
        if (m_py != s.exp_paddle || m_miss != s.exp_miss) begin
            $display("Model ended at paddle %0d and %0d misses, the table expects %0d and %0d",
                     m_py, m_miss, s.exp_paddle, s.exp_miss);
            errors++;
            step_errors++;
        end
    endtask

    // Watchdog for the whole run
    initial begin
        #5ms;
        $display("Timeout: the simulation did not finish in time");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        int   wait_cnt;
        logic val;
        enable       = 1'b0;
        btn_up_raw   = 1'b0;
        btn_down_raw = 1'b0;
        qx           = '0;
        qy           = '0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        m_bx = W / 2;
        m_by = H / 2;
        m_dx = 1;
        m_dy = 1;
        m_py = (H - PH) / 2;
        m_miss = 0;

        wait_cnt = 0;
        while (rst_n !== 1'b1 && wait_cnt < 100) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (rst_n !== 1'b1) begin
            $display("Reset was never released");
            errors++;
            tests_failed++;
        end else begin
            step_errors = 0;
            sample_pixel(W / 2, H / 2, val);
            check_pixel(1'b1, val, W / 2, H / 2);
            sample_pixel(40, 5, val);
            check_pixel(1'b0, val, 40, 5);
            sample_pixel(17, 20, val);
            check_pixel(1'b1, val, 17, 20);
            check_miss('0, miss_count);
            $display("Reset check: %0d errors", step_errors);
            if (step_errors == 0) tests_passed++;
            else tests_failed++;

            for (int i = 0; i < NUM_STEPS; i++) begin
                step_errors = 0;
                run_step(steps[i]);
                $display("Step %0d: %0d strobes, %0d errors", i, steps[i].strobes, step_errors);
                if (step_errors == 0) tests_passed++;
                else tests_failed++;
            end
        end

        $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
hdl/pong_pkg.sv
hdl/button_debounce.sv
hdl/pong_physics.sv
hdl/pong_renderer.sv
hdl/pong_top.sv
tests/clock_gen.sv
tests/pong_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= pong_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

FAIL_TEXT = FAIL: see errors above

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@grep -q "PASS: all tests" $(LOG) || { echo "Simulation did not complete"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
